//--- include/acore_defines.svh
`ifndef ACORE_DEFINES_SVH
`define ACORE_DEFINES_SVH

// interleaving and PI grouping
`define ACORE_NTI 16
`define ACORE_NOUT 4

// PI code in 512ths of a sample interval
`define ACORE_NPI 9

// ADC magnitude bits
`define ACORE_NADC 8

// cursor plus three post-cursors
`define ACORE_NTAPS 4

// signed widths of taps and emulated levels
`define ACORE_TAP_W 8
`define ACORE_SAMP_W 12

// default channel after reset
`define ACORE_TAP0_RST 64
`define ACORE_TAP1_RST 16
`define ACORE_TAP2_RST 8
`define ACORE_TAP3_RST 0

`endif

//--- src/const_pack.sv
`include "acore_defines.svh"

package const_pack;

    // one received word, bit 0 is the earliest symbol
    typedef logic [`ACORE_NTI-1:0] bits_word_t;

    // phase interpolator code
    typedef logic [`ACORE_NPI-1:0] pi_code_t;

    // channel tap, two's complement
    typedef logic signed [`ACORE_TAP_W-1:0] tap_t;

    // emulated analog level at one slice
    typedef logic signed [`ACORE_SAMP_W-1:0] sample_t;

    // ADC magnitude
    typedef logic [`ACORE_NADC-1:0] mag_t;

endpackage

//--- src/acore_cfg_regs.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module acore_cfg_regs import const_pack::*; (
    input  logic       clk,
    input  logic       rst_n,

    // tap write strobe
    input  logic       cfg_wr,
    input  logic [1:0] cfg_addr,
    input  tap_t       cfg_data,

    // taps seen by the channel model
    output tap_t       taps [`ACORE_NTAPS-1:0]
);

    localparam int NTAPS = `ACORE_NTAPS;

    // default channel, keyed by tap index
    localparam tap_t TAP_RST [NTAPS-1:0] = '{
        0: tap_t'(`ACORE_TAP0_RST),
        1: tap_t'(`ACORE_TAP1_RST),
        2: tap_t'(`ACORE_TAP2_RST),
        3: tap_t'(`ACORE_TAP3_RST)
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < NTAPS; j++) begin
                taps[j] <= TAP_RST[j];
            end
        end else if (cfg_wr) begin
            // only the addressed tap moves, the rest hold
            taps[cfg_addr] <= cfg_data;
        end
    end

endmodule

//--- src/channel_isi.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module channel_isi import const_pack::*; (
    input  logic       clk,
    input  logic       rst_n,

    // received symbols for this word
    input  bits_word_t bits,

    // cursor first, then post-cursors
    input  tap_t       taps [`ACORE_NTAPS-1:0],

    // one level per slice
    output sample_t    samples [`ACORE_NTI-1:0]
);

    localparam int NTI    = `ACORE_NTI;
    localparam int NTAPS  = `ACORE_NTAPS;
    localparam int HIST_W = NTAPS - 1;

    // tail of the previous word, zero reads as symbol -1
    logic [HIST_W-1:0] hist;

    // history below the current word, so index k+HIST_W is slice k
    logic [NTI+HIST_W-1:0] sym_ext;

    sample_t level [NTI-1:0];

    assign sym_ext = {bits, hist};

    // post-cursor FIR, all slices in parallel
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            level[k] = '0;
            for (int j = 0; j < NTAPS; j++) begin
                // symbol at position k-j
                if (sym_ext[k - j + HIST_W]) begin
                    level[k] = level[k] + sample_t'(taps[j]);
                end else begin
                    level[k] = level[k] - sample_t'(taps[j]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist <= '0;
            for (int k = 0; k < NTI; k++) begin
                samples[k] <= '0;
            end
        end else begin
            // last symbols of this word feed the next one
            hist <= bits[NTI-1 -: HIST_W];
            for (int k = 0; k < NTI; k++) begin
                samples[k] <= level[k];
            end
        end
    end

endmodule

//--- src/pi_phase_mix.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module pi_phase_mix import const_pack::*; (
    input  logic     clk,
    input  logic     rst_n,

    // levels from the channel stage
    input  sample_t  samples_in [`ACORE_NTI-1:0],

    // one code per group of slices
    input  pi_code_t ctl_pi [`ACORE_NOUT-1:0],

    // levels at the shifted sampling points
    output sample_t  samples_out [`ACORE_NTI-1:0]
);

    localparam int NTI    = `ACORE_NTI;
    localparam int W      = `ACORE_SAMP_W;
    localparam int NPI    = `ACORE_NPI;
    localparam int GRP    = `ACORE_NTI / `ACORE_NOUT;
    localparam int PROD_W = W + NPI + 2;

    // slice 15 of the previous input word
    sample_t prev_last;

    sample_t                   pred  [NTI-1:0];
    logic signed [W:0]         diff  [NTI-1:0];
    logic signed [PROD_W-1:0]  prod  [NTI-1:0];
    logic signed [PROD_W-1:0]  mixed [NTI-1:0];

    // earlier neighbor of every slice
    always_comb begin
        pred[0] = prev_last;
        for (int k = 1; k < NTI; k++) begin
            pred[k] = samples_in[k-1];
        end
    end

    // s[k] + ((s[k-1] - s[k]) * code) >>> NPI
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            diff[k]  = pred[k] - samples_in[k];
            prod[k]  = diff[k] * $signed({1'b0, ctl_pi[k / GRP]});
            mixed[k] = samples_in[k] + (prod[k] >>> NPI);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_last <= '0;
            for (int k = 0; k < NTI; k++) begin
                samples_out[k] <= '0;
            end
        end else begin
            prev_last <= samples_in[NTI-1];
            // result stays between the two neighbors, so it fits
            for (int k = 0; k < NTI; k++) begin
                samples_out[k] <= mixed[k][W-1:0];
            end
        end
    end

endmodule

//--- src/adc_quantizer.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module adc_quantizer import const_pack::*; (
    input  logic       clk,
    input  logic       rst_n,

    // mixed levels
    input  sample_t    samples [`ACORE_NTI-1:0],

    // sign and magnitude per slice
    output mag_t       adder_out [`ACORE_NTI-1:0],
    output bits_word_t sign_out
);

    localparam int NTI = `ACORE_NTI;
    localparam int W   = `ACORE_SAMP_W;

    // full scale of the magnitude
    localparam logic [W:0] MAG_MAX = (1 << `ACORE_NADC) - 1;

    // one extra bit so that the most negative level has an absolute value
    logic signed [W:0] ext_val [NTI-1:0];
    logic [W:0]        abs_val [NTI-1:0];
    mag_t              mag_next [NTI-1:0];
    bits_word_t        sign_next;

    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            ext_val[k]   = {samples[k][W-1], samples[k]};
            abs_val[k]   = ext_val[k][W] ? -ext_val[k] : ext_val[k];
            // zero counts as positive
            sign_next[k] = ~samples[k][W-1];
            if (abs_val[k] > MAG_MAX) begin
                mag_next[k] = MAG_MAX[`ACORE_NADC-1:0];
            end else begin
                mag_next[k] = abs_val[k][`ACORE_NADC-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_out <= '0;
            for (int k = 0; k < NTI; k++) begin
                adder_out[k] <= '0;
            end
        end else begin
            sign_out <= sign_next;
            for (int k = 0; k < NTI; k++) begin
                adder_out[k] <= mag_next[k];
            end
        end
    end

endmodule

//--- src/analog_core.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module analog_core import const_pack::*; (
    // emulator clock and reset
    input  logic       clk,
    input  logic       rst_n,

    // received bits, one word per cycle
    input  bits_word_t bits,

    // PI codes, one per group of four slices
    input  pi_code_t   ctl_pi [`ACORE_NOUT-1:0],

    // channel tap writes
    input  logic       cfg_wr,
    input  logic [1:0] cfg_addr,
    input  tap_t       cfg_data,

    // ADC outputs
    output mag_t       adder_out [`ACORE_NTI-1:0],
    output bits_word_t sign_out
);

    // taps currently in force
    tap_t    taps [`ACORE_NTAPS-1:0];

    // channel output, one cycle after bits
    sample_t ch_samples [`ACORE_NTI-1:0];

    // interpolated levels, two cycles after bits
    sample_t mix_samples [`ACORE_NTI-1:0];

    acore_cfg_regs u_cfg (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .taps     (taps)
    );

    channel_isi u_channel (
        .clk     (clk),
        .rst_n   (rst_n),
        .bits    (bits),
        .taps    (taps),
        .samples (ch_samples)
    );

    // ctl_pi is taken here, one cycle after the bits
    pi_phase_mix u_mix (
        .clk         (clk),
        .rst_n       (rst_n),
        .samples_in  (ch_samples),
        .ctl_pi      (ctl_pi),
        .samples_out (mix_samples)
    );

    adc_quantizer u_adc (
        .clk       (clk),
        .rst_n     (rst_n),
        .samples   (mix_samples),
        .adder_out (adder_out),
        .sign_out  (sign_out)
    );

endmodule

//--- testbench/tb_analog_core.sv
`timescale 1ns/1ps

`include "acore_defines.svh"

module tb_analog_core import const_pack::*; ();

    localparam int NTI    = `ACORE_NTI;
    localparam int NOUT   = `ACORE_NOUT;
    localparam int NPI    = `ACORE_NPI;
    localparam int NADC   = `ACORE_NADC;
    localparam int NTAPS  = `ACORE_NTAPS;
    localparam int GRP    = NTI / NOUT;
    localparam int HIST_W = NTAPS - 1;

    localparam int MAG_MAX = (1 << NADC) - 1;

    localparam int CLK_HALF_NS    = 2;
    localparam int RST_CYCLES     = 4;
    localparam int SETTLE_TIMEOUT = 20;
    localparam int WATCHDOG_NS    = 20000;

    localparam logic [31:0] SEED = 32'he122_3aa8;

    // steady level with every symbol equal under the default channel
    localparam int DEFAULT_SUM = `ACORE_TAP0_RST + `ACORE_TAP1_RST
                               + `ACORE_TAP2_RST + `ACORE_TAP3_RST;

    // alternating symbols with a negative first post-cursor
    localparam int ALT_CURSOR = 64;
    localparam int ALT_POST   = -24;
    localparam int ALT_MAG    = ALT_CURSOR - ALT_POST;

    logic       clk;
    logic       rst_n;
    bits_word_t bits;
    pi_code_t   ctl_pi [NOUT-1:0];
    logic       cfg_wr;
    logic [1:0] cfg_addr;
    tap_t       cfg_data;
    mag_t       adder_out [NTI-1:0];
    bits_word_t sign_out;

    // all magnitudes side by side with slice 0 in the low byte
    logic [NTI*NADC-1:0] mag_flat;

    // reference model state
    tap_t              taps_m [NTAPS-1:0];
    logic [HIST_W-1:0] hist_m;
    int                chan_lvl [NTI-1:0];
    int                mix_lvl [NTI-1:0];
    int                mix_new [NTI-1:0];
    int                prev_last_m;

    // expected outputs after the most recent rising edge
    logic [NTI*NADC-1:0] exp_mag_flat;
    bits_word_t          exp_sign;
    logic                check_en = 1'b0;
    logic                in_reset = 1'b0;

    int mag_errors;
    int sign_errors;
    int settle_errors;

    analog_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bits      (bits),
        .ctl_pi    (ctl_pi),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .adder_out (adder_out),
        .sign_out  (sign_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF_NS) clk = ~clk;
    end

    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            mag_flat[k*NADC +: NADC] = adder_out[k];
        end
    end

    // slice level from the ISI rule with symbol +1 for bit 1 and -1 for bit 0
    function automatic int channel_level(bits_word_t word, logic [HIST_W-1:0] hist, int k);
        int   sum;
        int   pos;
        logic sym;
        sum = 0;
        for (int j = 0; j < NTAPS; j++) begin
            pos = k - j;
            // negative positions come from the previous word's tail
            sym = (pos >= 0) ? word[pos] : hist[HIST_W + pos];
            sum = sym ? sum + int'(taps_m[j]) : sum - int'(taps_m[j]);
        end
        return sum;
    endfunction

    // move toward the earlier sample by code/512 of the gap
    function automatic int mix_level(int cur, int pred, int code);
        return cur + (((pred - cur) * code) >>> NPI);
    endfunction

    function automatic mag_t magnitude(int value);
        int abs_v;
        abs_v = (value < 0) ? -value : value;
        if (abs_v > MAG_MAX) begin
            return mag_t'(MAG_MAX);
        end
        return mag_t'(abs_v);
    endfunction

    // three-stage model advanced on the same edges as the DUT
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps_m[0]   = tap_t'(`ACORE_TAP0_RST);
            taps_m[1]   = tap_t'(`ACORE_TAP1_RST);
            taps_m[2]   = tap_t'(`ACORE_TAP2_RST);
            taps_m[3]   = tap_t'(`ACORE_TAP3_RST);
            hist_m      = '0;
            prev_last_m = 0;
            for (int k = 0; k < NTI; k++) begin
                chan_lvl[k] = 0;
                mix_lvl[k]  = 0;
            end
            exp_mag_flat <= '0;
            exp_sign     <= '0;
            check_en     <= 1'b0;
            in_reset     <= 1'b1;
        end else begin
            // mixer stage uses the channel word of the previous edge
            for (int k = 0; k < NTI; k++) begin
                mix_new[k] = mix_level(chan_lvl[k], (k == 0) ? prev_last_m : chan_lvl[k-1],
                                       int'(ctl_pi[k / GRP]));
            end
            prev_last_m = chan_lvl[NTI-1];

            // quantizer stage
            for (int k = 0; k < NTI; k++) begin
                exp_mag_flat[k*NADC +: NADC] <= magnitude(mix_lvl[k]);
                exp_sign[k]                  <= (mix_lvl[k] >= 0);
                mix_lvl[k]                    = mix_new[k];
            end

            // channel stage sees the taps in force before this edge
            for (int k = 0; k < NTI; k++) begin
                chan_lvl[k] = channel_level(bits, hist_m, k);
            end
            hist_m = bits[NTI-1 -: HIST_W];
            if (cfg_wr) begin
                taps_m[cfg_addr] = cfg_data;
            end
            check_en <= 1'b1;
            in_reset <= 1'b0;
        end
    end

    // outputs are stable at the falling edge
    reset_mag_zero: assert property (@(negedge clk) disable iff (!in_reset) mag_flat == '0)
        else begin
            $display("FAILED adder_out in reset: got %h expected %h", mag_flat, {NTI*NADC{1'b0}});
            mag_errors++;
        end

    reset_sign_zero: assert property (@(negedge clk) disable iff (!in_reset) sign_out == '0)
        else begin
            $display("FAILED sign_out in reset: got %h expected %h", sign_out, {NTI{1'b0}});
            sign_errors++;
        end

    mag_match: assert property (@(negedge clk) disable iff (!check_en) mag_flat == exp_mag_flat)
        else begin
            $display("FAILED adder_out: got %h expected %h", mag_flat, exp_mag_flat);
            mag_errors++;
        end

    sign_match: assert property (@(negedge clk) disable iff (!check_en) sign_out == exp_sign)
        else begin
            $display("FAILED sign_out: got %h expected %h", sign_out, exp_sign);
            sign_errors++;
        end

    // one word per falling edge with an optional tap write
    task automatic drive_word(input bits_word_t word, input bit rand_pi, input bit wr,
                              input logic [1:0] addr, input tap_t data);
        @(negedge clk);
        bits = word;
        for (int n = 0; n < NOUT; n++) begin
            ctl_pi[n] = rand_pi ? pi_code_t'($urandom) : '0;
        end
        cfg_wr   = wr;
        cfg_addr = addr;
        cfg_data = data;
    endtask

    task automatic write_tap(input logic [1:0] addr, input tap_t data);
        drive_word(bits_word_t'($urandom), 1'b0, 1'b1, addr, data);
    endtask

    task automatic run_random(input int cycles, input bit rand_pi, input bit rand_wr);
        bit wr;
        for (int i = 0; i < cycles; i++) begin
            wr = rand_wr && ($urandom_range(3) == 0);
            drive_word(bits_word_t'($urandom), rand_pi, wr, 2'($urandom_range(3)),
                       tap_t'($urandom));
        end
    endtask

    task automatic run_pattern(input bits_word_t word, input int cycles, input bit rand_pi);
        for (int i = 0; i < cycles; i++) begin
            drive_word(word, rand_pi, 1'b0, 2'd0, '0);
        end
    endtask

    // hold a word until every slice shows the given magnitude and signs
    task automatic settle_to(input bits_word_t word, input int mag, input bits_word_t signs);
        logic [NTI*NADC-1:0] want;
        bit                  done;
        want = {NTI{mag_t'(mag)}};
        done = 1'b0;
        for (int i = 0; i < SETTLE_TIMEOUT && !done; i++) begin
            drive_word(word, 1'b0, 1'b0, 2'd0, '0);
            done = (mag_flat == want) && (sign_out == signs);
        end
        if (!done) begin
            $display("outputs never settled to magnitude %0d for a constant word", mag);
            settle_errors++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        mag_errors    = 0;
        sign_errors   = 0;
        settle_errors = 0;
        rst_n    = 1'b0;
        bits     = '0;
        cfg_wr   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        for (int n = 0; n < NOUT; n++) begin
            ctl_pi[n] = '0;
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // constant words under the default channel
        settle_to('1, DEFAULT_SUM, '1);
        settle_to('0, DEFAULT_SUM, '0);

        // random data with PI at zero and then with random PI every cycle
        run_random(200, 1'b0, 1'b0);
        run_random(200, 1'b1, 1'b0);

        // large taps whose sum is beyond full scale
        write_tap(2'd0, tap_t'(127));
        write_tap(2'd1, tap_t'(100));
        write_tap(2'd2, tap_t'(60));
        write_tap(2'd3, tap_t'(50));
        settle_to('1, MAG_MAX, '1);
        run_random(150, 1'b1, 1'b1);

        // alternating symbols against a negative post-cursor
        write_tap(2'd0, tap_t'(ALT_CURSOR));
        write_tap(2'd1, tap_t'(ALT_POST));
        write_tap(2'd2, tap_t'(0));
        write_tap(2'd3, tap_t'(0));
        settle_to(16'h5555, ALT_MAG, 16'h5555);
        run_pattern(16'h5555, 60, 1'b1);
        run_pattern(16'h5555, 4, 1'b0);

        $display("errors: adder_out %0d, sign_out %0d, settle %0d",
                 mag_errors, sign_errors, settle_errors);
        if (mag_errors + sign_errors + settle_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
src/const_pack.sv
src/acore_cfg_regs.sv
src/channel_isi.sv
src/pi_phase_mix.sv
src/adc_quantizer.sv
src/analog_core.sv
testbench/tb_analog_core.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_analog_core -o tb_analog_core || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_analog_core)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
